//--- core_ctrl_pkg.sv
////////////////////
// Core control package
// CSR addresses, controller state encoding, mcause layout
// and the widths shared by the control blocks
////////////////////

package core_ctrl_pkg;

  // Interrupt id width, 32 request lines
  localparam int unsigned IRQ_ID_W      = 5;
  localparam int unsigned MCAUSE_CODE_W = 31;  // mcause exception code field

  typedef logic [11:0] csr_addr_t;

  ////////////////////
  // CSR addresses
  ////////////////////
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;
  localparam csr_addr_t CSR_MIP     = 12'h344;
  localparam csr_addr_t CSR_DPC     = 12'h7B1;  // Debug mode only for writes
  localparam csr_addr_t CSR_MCYCLE  = 12'hB00;
  localparam csr_addr_t CSR_MCYCLEH = 12'hB80;

  // mtvec mode field, direct is 2'b00
  localparam logic [1:0] MTVEC_MODE_VECTORED = 2'b01;

  // Controller states
  typedef enum logic [1:0] {
    ST_RESET = 2'b00,  // Waiting for fetch enable
    ST_RUN   = 2'b01,
    ST_SLEEP = 2'b10,  // After wfi
    ST_HALT  = 2'b11   // Debug halt
  } ctrl_state_e;

  // mcause fields
  typedef struct packed {
    logic                     irq;   // Set for interrupts
    logic [MCAUSE_CODE_W-1:0] code;
  } mcause_t;

  // Same word, raw for CSR reads, fields for trap entry
  typedef union packed {
    logic [31:0] raw;
    mcause_t     f;
  } mcause_u;

endpackage

//--- irq_select.sv
////////////////////
// Interrupt select
// Masks the request bus with mie and reports the
// highest numbered enabled line
////////////////////

`timescale 1ns/1ps

module irq_select (
  input  logic [31:0]                      irq_i,          // Request lines, levels
  input  logic [31:0]                      mie_i,          // Per line enables
  output logic                             irq_pending_o,  // Any enabled request
  output logic [core_ctrl_pkg::IRQ_ID_W-1:0] irq_id_o
);

  import core_ctrl_pkg::*;

  logic [31:0] irq_masked;

  assign irq_masked    = irq_i & mie_i;
  assign irq_pending_o = |irq_masked;

  // Ascending scan, last hit wins so the top line has priority
  always_comb begin
    irq_id_o = '0;
    for (int unsigned i = 0; i < 32; i++) begin
      if (irq_masked[i]) begin
        irq_id_o = IRQ_ID_W'(i);
      end
    end
  end

endmodule

//--- cycle_counter.sv
////////////////////
// Cycle counter
// mcycle/mcycleh, counts only while running and
// accepts CSR writes to either half
////////////////////

`timescale 1ns/1ps

module cycle_counter #(
  parameter int unsigned MCYCLE_W = 64  // 33 to 64
) (
  input  logic                     clk,
  input  logic                     rst_ni,
  input  logic                     count_en_i,  // High in run state only
  input  logic                     csr_we_i,
  input  core_ctrl_pkg::csr_addr_t csr_addr_i,
  input  logic [31:0]              csr_wdata_i,
  output logic [63:0]              mcycle_o     // Zero extended count
);

  import core_ctrl_pkg::*;

  logic [MCYCLE_W-1:0] cnt_q;
  logic                wr_lo;
  logic                wr_hi;

  assign wr_lo = csr_we_i && (csr_addr_i == CSR_MCYCLE);
  assign wr_hi = csr_we_i && (csr_addr_i == CSR_MCYCLEH);

  // A write replaces the increment for that cycle
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (wr_lo) begin
      cnt_q[31:0] <= csr_wdata_i;
    end else if (wr_hi) begin
      cnt_q[MCYCLE_W-1:32] <= csr_wdata_i[MCYCLE_W-33:0];  // Upper bits only
    end else if (count_en_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign mcycle_o = 64'(cnt_q);

endmodule

//--- core_ctrl_fsm.sv
////////////////////
// Core controller FSM
// Boot, interrupt entry, mret, wfi sleep and debug
// halt/resume. Registers the PC redirect, the target
// and the status levels, strobes trap save/restore
////////////////////

`timescale 1ns/1ps

module core_ctrl_fsm (
  input  logic                               clk,
  input  logic                               rst_ni,
  input  logic                               fetch_enable_i,
  input  logic [31:0]                        boot_addr_i,
  input  logic [31:0]                        dm_halt_addr_i,
  input  logic                               wfi_i,           // Pulses
  input  logic                               mret_i,
  input  logic                               dret_i,
  input  logic                               debug_req_i,
  input  logic                               irq_pending_i,   // From irq_select
  input  logic [core_ctrl_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  logic                               mstatus_mie_i,   // Global enable
  input  logic [29:0]                        mtvec_base_i,
  input  logic [1:0]                         mtvec_mode_i,
  input  logic [31:0]                        mepc_i,
  input  logic [31:0]                        dpc_i,
  output logic                               pc_set_o,
  output logic [31:0]                        pc_target_o,
  output logic                               irq_ack_o,
  output logic [core_ctrl_pkg::IRQ_ID_W-1:0] irq_id_o,
  output logic                               save_irq_o,      // CSR update strobes
  output logic                               save_debug_o,
  output logic                               restore_mret_o,
  output logic                               restore_dret_o,
  output logic                               count_en_o,
  output logic                               core_sleep_o,
  output logic                               debug_havereset_o,
  output logic                               debug_running_o,
  output logic                               debug_halted_o
);

  import core_ctrl_pkg::*;

  ctrl_state_e state_q, state_d;
  logic        pc_set_d;
  logic [31:0] pc_target_d;
  logic [31:0] irq_target;

  // Direct mode uses the base, vectored adds 4*id
  assign irq_target = {mtvec_base_i, 2'b00} +
                      ((mtvec_mode_i == MTVEC_MODE_VECTORED) ? (32'(irq_id_i) << 2) : 32'd0);

  ////////////////////
  // Next state and cause select
  ////////////////////
  always_comb begin
    state_d        = state_q;
    pc_set_d       = 1'b0;
    pc_target_d    = boot_addr_i;
    save_irq_o     = 1'b0;
    save_debug_o   = 1'b0;
    restore_mret_o = 1'b0;
    restore_dret_o = 1'b0;
    unique case (state_q)
      ST_RESET: begin
        if (fetch_enable_i) begin
          state_d  = ST_RUN;
          pc_set_d = 1'b1;  // Jump to boot address
        end
      end
      ST_RUN: begin
        if (debug_req_i) begin  // Debug beats interrupt
          state_d      = ST_HALT;
          pc_set_d     = 1'b1;
          pc_target_d  = dm_halt_addr_i;
          save_debug_o = 1'b1;
        end else if (irq_pending_i && mstatus_mie_i) begin
          pc_set_d    = 1'b1;
          pc_target_d = irq_target;
          save_irq_o  = 1'b1;
        end else if (mret_i) begin
          pc_set_d       = 1'b1;
          pc_target_d    = mepc_i;
          restore_mret_o = 1'b1;
        end else if (wfi_i) begin
          state_d = ST_SLEEP;
        end
      end
      ST_SLEEP: begin
        if (debug_req_i) begin
          state_d      = ST_HALT;
          pc_set_d     = 1'b1;
          pc_target_d  = dm_halt_addr_i;
          save_debug_o = 1'b1;
        end else if (irq_pending_i) begin
          state_d = ST_RUN;  // Wake even with mstatus.mie clear
        end
      end
      ST_HALT: begin
        if (dret_i) begin
          state_d        = ST_RUN;
          pc_set_d       = 1'b1;
          pc_target_d    = dpc_i;
          restore_dret_o = 1'b1;
        end
      end
      default: state_d = ST_RESET;
    endcase
  end

  ////////////////////
  // State and status flops
  ////////////////////
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q           <= ST_RESET;
      pc_set_o          <= 1'b0;
      irq_ack_o         <= 1'b0;
      count_en_o        <= 1'b0;
      core_sleep_o      <= 1'b0;
      debug_havereset_o <= 1'b1;  // Until first boot
      debug_running_o   <= 1'b0;
      debug_halted_o    <= 1'b0;
    end else begin
      state_q           <= state_d;
      pc_set_o          <= pc_set_d;
      irq_ack_o         <= save_irq_o;
      count_en_o        <= (state_d == ST_RUN);
      core_sleep_o      <= (state_d == ST_SLEEP);
      debug_havereset_o <= (state_d == ST_RESET);
      debug_running_o   <= (state_d == ST_RUN) || (state_d == ST_SLEEP);
      debug_halted_o    <= (state_d == ST_HALT);
    end
  end

  // Redirect payload, only qualified by pc_set_o / irq_ack_o
  always_ff @(posedge clk) begin
    if (pc_set_d) begin
      pc_target_o <= pc_target_d;
    end
    if (save_irq_o) begin
      irq_id_o <= irq_id_i;
    end
  end

endmodule

//--- ctrl_csrs.sv
////////////////////
// Control CSRs
// mstatus, mie, mtvec, mepc, mcause, mip, dpc and the
// mcycle read path. Trap entry and return updates
// take priority over software writes
////////////////////

`timescale 1ns/1ps

module ctrl_csrs (
  input  logic                               clk,
  input  logic                               rst_ni,
  input  logic [31:0]                        mtvec_addr_i,   // mtvec reset value
  input  logic [31:0]                        irq_i,          // Read back as mip
  input  logic                               csr_we_i,
  input  core_ctrl_pkg::csr_addr_t           csr_addr_i,
  input  logic [31:0]                        csr_wdata_i,
  input  logic [31:0]                        pc_i,
  input  logic [core_ctrl_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  logic                               save_irq_i,
  input  logic                               save_debug_i,
  input  logic                               restore_mret_i,
  input  logic                               restore_dret_i,
  input  logic [63:0]                        mcycle_i,
  output logic [31:0]                        csr_rdata_o,    // Combinational read
  output logic [31:0]                        mie_o,
  output logic                               mstatus_mie_o,
  output logic [29:0]                        mtvec_base_o,
  output logic [1:0]                         mtvec_mode_o,
  output logic [31:0]                        mepc_o,
  output logic [31:0]                        dpc_o
);

  import core_ctrl_pkg::*;

  logic    mstatus_mie_q;
  logic    mstatus_mpie_q;
  logic    dbg_mode_q;      // Between halt and dret
  mcause_u mcause_q;

  // Write decodes
  logic wr_mstatus, wr_mie, wr_mtvec, wr_mepc, wr_mcause, wr_dpc;

  assign wr_mstatus = csr_we_i && (csr_addr_i == CSR_MSTATUS);
  assign wr_mie     = csr_we_i && (csr_addr_i == CSR_MIE);
  assign wr_mtvec   = csr_we_i && (csr_addr_i == CSR_MTVEC);
  assign wr_mepc    = csr_we_i && (csr_addr_i == CSR_MEPC);
  assign wr_mcause  = csr_we_i && (csr_addr_i == CSR_MCAUSE);
  assign wr_dpc     = csr_we_i && (csr_addr_i == CSR_DPC) && dbg_mode_q;

  ////////////////////
  // Control state
  ////////////////////
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mie_o          <= '0;
      mtvec_base_o   <= mtvec_addr_i[31:2];
      mtvec_mode_o   <= 2'b00;  // Direct
      dbg_mode_q     <= 1'b0;
    end else begin
      if (save_irq_i) begin
        mstatus_mpie_q <= mstatus_mie_q;  // Stack the enable
        mstatus_mie_q  <= 1'b0;
      end else if (restore_mret_i) begin
        mstatus_mie_q  <= mstatus_mpie_q;
        mstatus_mpie_q <= 1'b1;
      end else if (wr_mstatus) begin
        mstatus_mie_q  <= csr_wdata_i[3];
        mstatus_mpie_q <= csr_wdata_i[7];
      end
      if (wr_mie) begin
        mie_o <= csr_wdata_i;
      end
      if (wr_mtvec) begin
        mtvec_base_o <= csr_wdata_i[31:2];
        // Only direct and vectored are legal
        mtvec_mode_o <= (csr_wdata_i[1:0] == MTVEC_MODE_VECTORED) ? MTVEC_MODE_VECTORED : 2'b00;
      end
      if (save_debug_i) begin
        dbg_mode_q <= 1'b1;
      end else if (restore_dret_i) begin
        dbg_mode_q <= 1'b0;
      end
    end
  end

  ////////////////////
  // Trap payload
  ////////////////////
  always_ff @(posedge clk) begin
    if (save_irq_i) begin
      mepc_o <= pc_i;
    end else if (wr_mepc) begin
      mepc_o <= {csr_wdata_i[31:1], 1'b0};  // Halfword aligned
    end
    if (save_irq_i) begin
      mcause_q.f.irq  <= 1'b1;
      mcause_q.f.code <= MCAUSE_CODE_W'(irq_id_i);
    end else if (wr_mcause) begin
      mcause_q.raw <= csr_wdata_i;
    end
    if (save_debug_i) begin
      dpc_o <= pc_i;  // Resume address for dret
    end else if (wr_dpc) begin
      dpc_o <= {csr_wdata_i[31:1], 1'b0};
    end
  end

  assign mstatus_mie_o = mstatus_mie_q;

  // Read mux, unknown addresses read as zero
  always_comb begin
    unique case (csr_addr_i)
      CSR_MSTATUS: csr_rdata_o = {19'b0, 2'b11, 3'b0, mstatus_mpie_q, 3'b0, mstatus_mie_q, 3'b0};
      CSR_MIE:     csr_rdata_o = mie_o;
      CSR_MTVEC:   csr_rdata_o = {mtvec_base_o, mtvec_mode_o};
      CSR_MEPC:    csr_rdata_o = mepc_o;
      CSR_MCAUSE:  csr_rdata_o = mcause_q.raw;
      CSR_MIP:     csr_rdata_o = irq_i;  // Pending is the raw request bus
      CSR_DPC:     csr_rdata_o = dpc_o;
      CSR_MCYCLE:  csr_rdata_o = mcycle_i[31:0];
      CSR_MCYCLEH: csr_rdata_o = mcycle_i[63:32];
      default:     csr_rdata_o = '0;
    endcase
  end

endmodule

//--- core_ctrl_top.sv
////////////////////
// Core control top
// Connects the FSM, interrupt select, CSRs and
// cycle counter to the outside ports
////////////////////

`timescale 1ns/1ps

module core_ctrl_top #(
  parameter int unsigned MCYCLE_W = 64
) (
  input  logic                               clk,
  input  logic                               rst_ni,
  // Static addresses
  input  logic [31:0]                        boot_addr_i,
  input  logic [31:0]                        mtvec_addr_i,
  input  logic [31:0]                        dm_halt_addr_i,
  // Levels
  input  logic                               fetch_enable_i,
  input  logic [31:0]                        irq_i,
  input  logic                               debug_req_i,
  // Abstracted instruction stream
  input  logic [31:0]                        pc_i,
  input  logic                               wfi_i,
  input  logic                               mret_i,
  input  logic                               dret_i,
  // CSR port
  input  logic                               csr_we_i,
  input  core_ctrl_pkg::csr_addr_t           csr_addr_i,
  input  logic [31:0]                        csr_wdata_i,
  output logic [31:0]                        csr_rdata_o,
  // Redirect and status
  output logic                               pc_set_o,
  output logic [31:0]                        pc_target_o,
  output logic                               irq_ack_o,
  output logic [core_ctrl_pkg::IRQ_ID_W-1:0] irq_id_o,
  output logic                               core_sleep_o,
  output logic                               debug_havereset_o,
  output logic                               debug_running_o,
  output logic                               debug_halted_o
);

  import core_ctrl_pkg::*;

  logic                irq_pending;
  logic [IRQ_ID_W-1:0] irq_id;       // Winning line, combinational
  logic [31:0]         mie;
  logic                mstatus_mie;
  logic [29:0]         mtvec_base;
  logic [1:0]          mtvec_mode;
  logic [31:0]         mepc;
  logic [31:0]         dpc;
  logic                save_irq, save_debug, restore_mret, restore_dret;
  logic                count_en;
  logic [63:0]         mcycle;

  irq_select irq_select_i (
    .irq_i         (irq_i),
    .mie_i         (mie),
    .irq_pending_o (irq_pending),
    .irq_id_o      (irq_id)
  );

  core_ctrl_fsm core_ctrl_fsm_i (
    .clk               (clk),
    .rst_ni            (rst_ni),
    .fetch_enable_i    (fetch_enable_i),
    .boot_addr_i       (boot_addr_i),
    .dm_halt_addr_i    (dm_halt_addr_i),
    .wfi_i             (wfi_i),
    .mret_i            (mret_i),
    .dret_i            (dret_i),
    .debug_req_i       (debug_req_i),
    .irq_pending_i     (irq_pending),
    .irq_id_i          (irq_id),
    .mstatus_mie_i     (mstatus_mie),
    .mtvec_base_i      (mtvec_base),
    .mtvec_mode_i      (mtvec_mode),
    .mepc_i            (mepc),
    .dpc_i             (dpc),
    .pc_set_o          (pc_set_o),
    .pc_target_o       (pc_target_o),
    .irq_ack_o         (irq_ack_o),
    .irq_id_o          (irq_id_o),
    .save_irq_o        (save_irq),
    .save_debug_o      (save_debug),
    .restore_mret_o    (restore_mret),
    .restore_dret_o    (restore_dret),
    .count_en_o        (count_en),
    .core_sleep_o      (core_sleep_o),
    .debug_havereset_o (debug_havereset_o),
    .debug_running_o   (debug_running_o),
    .debug_halted_o    (debug_halted_o)
  );

  ctrl_csrs ctrl_csrs_i (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .mtvec_addr_i   (mtvec_addr_i),
    .irq_i          (irq_i),
    .csr_we_i       (csr_we_i),
    .csr_addr_i     (csr_addr_i),
    .csr_wdata_i    (csr_wdata_i),
    .pc_i           (pc_i),
    .irq_id_i       (irq_id),
    .save_irq_i     (save_irq),
    .save_debug_i   (save_debug),
    .restore_mret_i (restore_mret),
    .restore_dret_i (restore_dret),
    .mcycle_i       (mcycle),
    .csr_rdata_o    (csr_rdata_o),
    .mie_o          (mie),
    .mstatus_mie_o  (mstatus_mie),
    .mtvec_base_o   (mtvec_base),
    .mtvec_mode_o   (mtvec_mode),
    .mepc_o         (mepc),
    .dpc_o          (dpc)
  );

  cycle_counter #(
    .MCYCLE_W (MCYCLE_W)
  ) cycle_counter_i (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .count_en_i  (count_en),
    .csr_we_i    (csr_we_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .mcycle_o    (mcycle)
  );

endmodule

//--- core_ctrl_props.sv
////////////////////
// Core control protocol checks
// Concurrent assertions on the redirect and
// status outputs, bound into the top level
////////////////////

`timescale 1ns/1ps

module core_ctrl_props (
  input logic clk,
  input logic rst_ni,
  input logic pc_set_i,
  input logic irq_ack_i,
  input logic core_sleep_i,
  input logic debug_running_i,
  input logic debug_halted_i
);

  int unsigned prop_fails = 0;  // Failure count

  ack_with_redirect: assert property (@(posedge clk) disable iff (!rst_ni)
    irq_ack_i |-> pc_set_i)
    else begin
      $error("irq_ack_o high without pc_set_o");
      prop_fails++;
    end

  sleep_not_halted: assert property (@(posedge clk) disable iff (!rst_ni)
    !(core_sleep_i && debug_halted_i))
    else begin
      $error("core_sleep_o and debug_halted_o high together");
      prop_fails++;
    end

  running_not_halted: assert property (@(posedge clk) disable iff (!rst_ni)
    !(debug_running_i && debug_halted_i))
    else begin
      $error("debug_running_o and debug_halted_o high together");
      prop_fails++;
    end

  // Redirect is a single cycle strobe
  single_pc_set: assert property (@(posedge clk) disable iff (!rst_ni)
    pc_set_i |=> !pc_set_i)
    else begin
      $error("pc_set_o high two cycles in a row");
      prop_fails++;
    end

endmodule

bind core_ctrl_top core_ctrl_props props_i (
  .clk             (clk),
  .rst_ni          (rst_ni),
  .pc_set_i        (pc_set_o),
  .irq_ack_i       (irq_ack_o),
  .core_sleep_i    (core_sleep_o),
  .debug_running_i (debug_running_o),
  .debug_halted_i  (debug_halted_o)
);

//--- tb_core_ctrl.sv
////////////////////
// Core control testbench
// Boot, interrupts in direct and vectored mode, mret,
// wfi sleep, debug halt/resume and the cycle counter
////////////////////

`timescale 1ns/1ps

module tb_core_ctrl;

  import core_ctrl_pkg::*;

  localparam logic [31:0] BOOT_ADDR    = 32'h0000_0080;
  localparam logic [31:0] MTVEC_ADDR   = 32'h0000_1000;  // mtvec reset value in direct mode
  localparam logic [31:0] VEC_BASE     = 32'h0000_2000;
  localparam logic [31:0] DM_HALT_ADDR = 32'h1A11_0800;
  localparam logic [31:0] MIE_EN       = 32'hFFFF_0000;  // Upper 16 lines enabled
  localparam int          MAX_CYCLES   = 2000;           // Tests take under 100 cycles

  logic clk, rst_ni, fetch_enable_i, debug_req_i;
  logic wfi_i, mret_i, dret_i, csr_we_i;
  logic [31:0] irq_i, pc_i, csr_wdata_i, csr_rdata_o, pc_target_o;
  csr_addr_t csr_addr_i;
  logic pc_set_o, irq_ack_o, core_sleep_o;
  logic debug_havereset_o, debug_running_o, debug_halted_o;
  logic [IRQ_ID_W-1:0] irq_id_o;

  int seed = 32'h1868;
  int cycle_cnt = 0;
  int test_errs, total_errs, tests_run, tests_failed;
  int id, n_run;
  string test_name;
  logic [31:0] rd, pc_a, req, cnt_base;
  mcause_u mc;

  core_ctrl_top #(.MCYCLE_W(64)) uut (
    .clk               (clk),
    .rst_ni            (rst_ni),
    .boot_addr_i       (BOOT_ADDR),
    .mtvec_addr_i      (MTVEC_ADDR),
    .dm_halt_addr_i    (DM_HALT_ADDR),
    .fetch_enable_i    (fetch_enable_i),
    .irq_i             (irq_i),
    .debug_req_i       (debug_req_i),
    .pc_i              (pc_i),
    .wfi_i             (wfi_i),
    .mret_i            (mret_i),
    .dret_i            (dret_i),
    .csr_we_i          (csr_we_i),
    .csr_addr_i        (csr_addr_i),
    .csr_wdata_i       (csr_wdata_i),
    .csr_rdata_o       (csr_rdata_o),
    .pc_set_o          (pc_set_o),
    .pc_target_o       (pc_target_o),
    .irq_ack_o         (irq_ack_o),
    .irq_id_o          (irq_id_o),
    .core_sleep_o      (core_sleep_o),
    .debug_havereset_o (debug_havereset_o),
    .debug_running_o   (debug_running_o),
    .debug_halted_o    (debug_halted_o)
  );

  always #50 clk = ~clk;  // 100 ns period

  // Run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Highest requested and enabled line or -1 for none
  function automatic int highest_line(input logic [31:0] lines, input logic [31:0] en);
    int hit;
    hit = -1;
    for (int i = 31; i >= 0; i--) begin
      if (lines[i] && en[i] && (hit < 0)) hit = i;
    end
    return hit;
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("Test %-14s ok", test_name);
    end else begin
      tests_failed++;
      $display("Test %-14s failed with %0d errors", test_name, test_errs);
    end
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  // One cycle write that leaves the address in place for reads
  task automatic csr_write(input csr_addr_t addr, input logic [31:0] data);
    @(posedge clk);
    csr_we_i    <= 1'b1;
    csr_addr_i  <= addr;
    csr_wdata_i <= data;
    @(posedge clk);
    csr_we_i    <= 1'b0;
  endtask

  task automatic csr_read(input csr_addr_t addr, output logic [31:0] data);
    @(posedge clk);
    csr_addr_i <= addr;
    @(negedge clk);
    data = csr_rdata_o;  // Combinational read path
  endtask

  initial begin
    clk            = 1'b0;
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    debug_req_i    = 1'b0;
    wfi_i          = 1'b0;
    mret_i         = 1'b0;
    dret_i         = 1'b0;
    csr_we_i       = 1'b0;
    irq_i          = '0;
    pc_i           = '0;
    csr_addr_i     = '0;
    csr_wdata_i    = '0;
    total_errs     = 0;
    tests_run      = 0;
    tests_failed   = 0;
    repeat (8) @(posedge clk);
    rst_ni <= 1'b1;

    ////////////////////
    // Boot
    start_test("boot");
    @(negedge clk);
    check_eq("havereset", 1, debug_havereset_o);
    check_eq("running", 0, debug_running_o);
    check_eq("pc_set idle", 0, pc_set_o);
    @(posedge clk);
    fetch_enable_i <= 1'b1;
    @(posedge clk);
    @(negedge clk);  // One cycle after fetch enable is seen
    check_eq("pc_set", 1, pc_set_o);
    check_eq("boot target", BOOT_ADDR, pc_target_o);
    check_eq("havereset off", 0, debug_havereset_o);
    check_eq("running", 1, debug_running_o);
    end_test();

    ////////////////////
    // Direct mode interrupt
    start_test("irq_direct");
    csr_write(CSR_MIE, MIE_EN);
    csr_write(CSR_MSTATUS, 32'h8);
    id   = 16 + ($random(seed) & 15);
    req  = (32'h1 << id) | (32'h1 << ($random(seed) & 15)) | 32'h0001_0000;
    pc_a = $random(seed) & 32'hFFFF_FFFC;
    @(posedge clk);
    irq_i <= req;
    pc_i  <= pc_a;
    @(posedge clk);
    irq_i <= '0;
    @(negedge clk);
    check_eq("pc_set", 1, pc_set_o);
    check_eq("ack", 1, irq_ack_o);
    check_eq("irq id", highest_line(req, MIE_EN), irq_id_o);
    check_eq("direct target", MTVEC_ADDR, pc_target_o);
    csr_read(CSR_MEPC, rd);
    check_eq("mepc", pc_a, rd);
    csr_read(CSR_MCAUSE, rd);
    mc.raw = rd;
    check_eq("mcause irq", 1, mc.f.irq);
    check_eq("mcause code", highest_line(req, MIE_EN), mc.f.code);
    csr_read(CSR_MSTATUS, rd);
    check_eq("mstatus.mie", 0, rd[3]);  // Cleared on entry
    end_test();

    ////////////////////
    // Vectored mode, masking, mret
    start_test("irq_vectored");
    csr_write(CSR_MTVEC, VEC_BASE | 32'(MTVEC_MODE_VECTORED));
    csr_write(CSR_MSTATUS, 32'h8);
    @(posedge clk);
    irq_i <= 32'h0000_0100;  // Line 8 is disabled
    repeat (3) begin
      @(negedge clk);
      check_eq("masked ack", 0, irq_ack_o);
      check_eq("masked pc_set", 0, pc_set_o);
    end
    id   = 16 + ($random(seed) & 15);
    pc_a = $random(seed) & 32'hFFFF_FFFC;
    req  = (32'h1 << id) | 32'h0000_0100;
    @(posedge clk);
    irq_i <= req;
    pc_i  <= pc_a;
    @(posedge clk);
    irq_i <= '0;
    @(negedge clk);
    check_eq("ack", 1, irq_ack_o);
    check_eq("irq id", highest_line(req, MIE_EN), irq_id_o);
    check_eq("vector target", VEC_BASE + 4 * highest_line(req, MIE_EN), pc_target_o);
    @(posedge clk);
    mret_i <= 1'b1;
    @(posedge clk);
    mret_i <= 1'b0;
    @(negedge clk);
    check_eq("mret pc_set", 1, pc_set_o);
    check_eq("mret target", pc_a, pc_target_o);
    csr_read(CSR_MSTATUS, rd);
    check_eq("mie from mpie", 1, rd[3]);
    end_test();

    ////////////////////
    // wfi sleep and wake with mstatus.mie clear
    start_test("sleep");
    csr_write(CSR_MSTATUS, 32'h0);
    @(posedge clk);
    wfi_i <= 1'b1;
    @(posedge clk);
    wfi_i <= 1'b0;
    @(negedge clk);
    check_eq("sleep", 1, core_sleep_o);
    @(posedge clk);
    irq_i <= 32'h0000_0004;  // Disabled line keeps it asleep
    repeat (3) begin
      @(negedge clk);
      check_eq("still asleep", 1, core_sleep_o);
    end
    id = 16 + ($random(seed) & 15);
    @(posedge clk);
    irq_i <= 32'h1 << id;
    @(posedge clk);
    @(negedge clk);
    check_eq("woken", 0, core_sleep_o);
    repeat (2) begin
      @(negedge clk);
      check_eq("no ack", 0, irq_ack_o);  // Global enable off
    end
    @(posedge clk);
    irq_i <= '0;
    end_test();

    ////////////////////
    // Debug halt beats interrupt and dret resumes
    start_test("debug");
    csr_write(CSR_MSTATUS, 32'h8);
    id   = 16 + ($random(seed) & 15);
    pc_a = $random(seed) & 32'hFFFF_FFFC;
    @(posedge clk);
    debug_req_i <= 1'b1;
    irq_i       <= 32'h1 << id;
    pc_i        <= pc_a;
    @(posedge clk);
    debug_req_i <= 1'b0;
    irq_i       <= '0;
    @(negedge clk);
    check_eq("halted", 1, debug_halted_o);
    check_eq("running", 0, debug_running_o);
    check_eq("pc_set", 1, pc_set_o);
    check_eq("halt target", DM_HALT_ADDR, pc_target_o);
    check_eq("no ack", 0, irq_ack_o);
    csr_read(CSR_DPC, rd);
    check_eq("dpc", pc_a, rd);
    @(posedge clk);
    dret_i <= 1'b1;
    @(posedge clk);
    dret_i <= 1'b0;
    @(negedge clk);
    check_eq("dret pc_set", 1, pc_set_o);
    check_eq("dret target", pc_a, pc_target_o);
    check_eq("running", 1, debug_running_o);
    check_eq("halted", 0, debug_halted_o);
    end_test();

    ////////////////////
    // mcycle counts run cycles and freezes in halt
    start_test("cycle_counter");
    cnt_base = $random(seed) & 32'h7FFF_FFFF;  // No carry into mcycleh
    n_run    = 10 + ($random(seed) & 15);
    csr_write(CSR_MCYCLE, cnt_base);
    repeat (n_run) @(posedge clk);
    @(negedge clk);
    check_eq("mcycle run", cnt_base + n_run, csr_rdata_o);
    @(posedge clk);
    debug_req_i <= 1'b1;
    @(posedge clk);
    debug_req_i <= 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    check_eq("halted", 1, debug_halted_o);
    check_eq("mcycle frozen", cnt_base + n_run + 2, csr_rdata_o);  // Two more run cycles
    @(posedge clk);
    dret_i <= 1'b1;
    @(posedge clk);
    dret_i <= 1'b0;
    @(negedge clk);
    check_eq("dret target", pc_a, pc_target_o);
    end_test();

    $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, total_errs, uut.props_i.prop_fails);
    if ((total_errs == 0) && (uut.props_i.prop_fails == 0)) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- flist.f
core_ctrl_pkg.sv
irq_select.sv
cycle_counter.sv
core_ctrl_fsm.sv
ctrl_csrs.sv
core_ctrl_top.sv
core_ctrl_props.sv
tb_core_ctrl.sv
